// File: verilog/id_pkg.sv
package id_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_JIRL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_kind_e;

    // primary opcode, inst[31:26]
    localparam logic [5:0] OP_GRP0    = 6'h00;
    localparam logic [5:0] OP_LU12I   = 6'h05;
    localparam logic [5:0] OP_PCADDU  = 6'h07;
    localparam logic [5:0] OP_JIRL    = 6'h13;
    localparam logic [5:0] OP_B       = 6'h14;
    localparam logic [5:0] OP_BL      = 6'h15;
    localparam logic [5:0] OP_BEQ     = 6'h16;
    localparam logic [5:0] OP_BNE     = 6'h17;
    localparam logic [5:0] OP_BLT     = 6'h18;
    localparam logic [5:0] OP_BGE     = 6'h19;
    localparam logic [5:0] OP_BLTU    = 6'h1a;
    localparam logic [5:0] OP_BGEU    = 6'h1b;

    // group 0 sub-opcode, inst[25:22]
    localparam logic [3:0] OPI_3R     = 4'h0;
    localparam logic [3:0] OPI_SHIFT  = 4'h1;
    localparam logic [3:0] OPI_SLTI   = 4'h8;
    localparam logic [3:0] OPI_SLTUI  = 4'h9;
    localparam logic [3:0] OPI_ADDI   = 4'ha;
    localparam logic [3:0] OPI_ANDI   = 4'hd;
    localparam logic [3:0] OPI_ORI    = 4'he;
    localparam logic [3:0] OPI_XORI   = 4'hf;

    // function field, inst[19:15]
    localparam logic [4:0] F_ADD      = 5'h00;
    localparam logic [4:0] F_SLLI     = 5'h01;
    localparam logic [4:0] F_SUB      = 5'h02;
    localparam logic [4:0] F_SLT      = 5'h04;
    localparam logic [4:0] F_SLTU     = 5'h05;
    localparam logic [4:0] F_NOR      = 5'h08;
    localparam logic [4:0] F_AND      = 5'h09;
    localparam logic [4:0] F_SRLI     = 5'h09;
    localparam logic [4:0] F_OR       = 5'h0a;
    localparam logic [4:0] F_XOR      = 5'h0b;
    localparam logic [4:0] F_SLL      = 5'h0e;
    localparam logic [4:0] F_SRL      = 5'h0f;
    localparam logic [4:0] F_SRA      = 5'h10;
    localparam logic [4:0] F_SRAI     = 5'h11;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic      write;
        logic      pending;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_src_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

    typedef struct packed {
        alu_op_e   alu_op;
        br_kind_e  br_kind;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      use_rj;
        logic      use_rkd;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        logic      gr_we;
        reg_addr_t dest;
        word_t     imm;
        word_t     br_offs;
        logic      ine;
    } dec_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      gr_we;
        reg_addr_t dest;
        word_t     imm;
        word_t     rj_value;
        word_t     rkd_value;
        word_t     pc;
        logic      ine;
    } exe_pkt_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  id_pkg::word_t inst,
    output id_pkg::dec_t  dec
);
    import id_pkg::*;

    logic [5:0]  op31_26;
    logic [3:0]  op25_22;
    logic [1:0]  op21_20;
    logic [4:0]  op19_15;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    logic grp_3r;
    logic grp_shift;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui;
    logic inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i;
    logic inst_b, inst_bl, inst_jirl;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic is_cond_br;
    logic legal;

    assign op31_26 = inst[31:26];
    assign op25_22 = inst[25:22];
    assign op21_20 = inst[21:20];
    assign op19_15 = inst[19:15];
    assign rd      = inst[4:0];
    assign rj      = inst[9:5];
    assign rk      = inst[14:10];
    assign i12     = inst[21:10];
    assign i20     = inst[24:5];
    assign i16     = inst[25:10];
    // si26 keeps its high part in the low bits of the word
    assign i26     = {inst[9:0], inst[25:10]};

    assign grp_3r    = (op31_26 == OP_GRP0) && (op25_22 == OPI_3R) && (op21_20 == 2'h1);
    assign grp_shift = (op31_26 == OP_GRP0) && (op25_22 == OPI_SHIFT) && (op21_20 == 2'h0);

    assign inst_add_w  = grp_3r && (op19_15 == F_ADD);
    assign inst_sub_w  = grp_3r && (op19_15 == F_SUB);
    assign inst_slt    = grp_3r && (op19_15 == F_SLT);
    assign inst_sltu   = grp_3r && (op19_15 == F_SLTU);
    assign inst_nor    = grp_3r && (op19_15 == F_NOR);
    assign inst_and    = grp_3r && (op19_15 == F_AND);
    assign inst_or     = grp_3r && (op19_15 == F_OR);
    assign inst_xor    = grp_3r && (op19_15 == F_XOR);
    assign inst_sll_w  = grp_3r && (op19_15 == F_SLL);
    assign inst_srl_w  = grp_3r && (op19_15 == F_SRL);
    assign inst_sra_w  = grp_3r && (op19_15 == F_SRA);
    assign inst_slli_w = grp_shift && (op19_15 == F_SLLI);
    assign inst_srli_w = grp_shift && (op19_15 == F_SRLI);
    assign inst_srai_w = grp_shift && (op19_15 == F_SRAI);

    assign inst_slti   = (op31_26 == OP_GRP0) && (op25_22 == OPI_SLTI);
    assign inst_sltui  = (op31_26 == OP_GRP0) && (op25_22 == OPI_SLTUI);
    assign inst_addi_w = (op31_26 == OP_GRP0) && (op25_22 == OPI_ADDI);
    assign inst_andi   = (op31_26 == OP_GRP0) && (op25_22 == OPI_ANDI);
    assign inst_ori    = (op31_26 == OP_GRP0) && (op25_22 == OPI_ORI);
    assign inst_xori   = (op31_26 == OP_GRP0) && (op25_22 == OPI_XORI);

    assign inst_lu12i_w   = (op31_26 == OP_LU12I) && !inst[25];
    assign inst_pcaddu12i = (op31_26 == OP_PCADDU) && !inst[25];

    assign inst_jirl = (op31_26 == OP_JIRL);
    assign inst_b    = (op31_26 == OP_B);
    assign inst_bl   = (op31_26 == OP_BL);
    assign inst_beq  = (op31_26 == OP_BEQ);
    assign inst_bne  = (op31_26 == OP_BNE);
    assign inst_blt  = (op31_26 == OP_BLT);
    assign inst_bge  = (op31_26 == OP_BGE);
    assign inst_bltu = (op31_26 == OP_BLTU);
    assign inst_bgeu = (op31_26 == OP_BGEU);

    assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign legal = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w
                 | inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti
                 | inst_sltui | inst_andi | inst_ori | inst_xori | inst_lu12i_w
                 | inst_pcaddu12i | inst_b | inst_bl | inst_jirl | is_cond_br;

    always_comb begin
        if (inst_sub_w)                     dec.alu_op = ALU_SUB;
        else if (inst_slt | inst_slti)      dec.alu_op = ALU_SLT;
        else if (inst_sltu | inst_sltui)    dec.alu_op = ALU_SLTU;
        else if (inst_and | inst_andi)      dec.alu_op = ALU_AND;
        else if (inst_nor)                  dec.alu_op = ALU_NOR;
        else if (inst_or | inst_ori)        dec.alu_op = ALU_OR;
        else if (inst_xor | inst_xori)      dec.alu_op = ALU_XOR;
        else if (inst_sll_w | inst_slli_w)  dec.alu_op = ALU_SLL;
        else if (inst_srl_w | inst_srli_w)  dec.alu_op = ALU_SRL;
        else if (inst_sra_w | inst_srai_w)  dec.alu_op = ALU_SRA;
        else if (inst_lu12i_w)              dec.alu_op = ALU_LUI;
        else                                dec.alu_op = ALU_ADD;

        if (inst_b)         dec.br_kind = BR_B;
        else if (inst_bl)   dec.br_kind = BR_BL;
        else if (inst_jirl) dec.br_kind = BR_JIRL;
        else if (inst_beq)  dec.br_kind = BR_BEQ;
        else if (inst_bne)  dec.br_kind = BR_BNE;
        else if (inst_blt)  dec.br_kind = BR_BLT;
        else if (inst_bge)  dec.br_kind = BR_BGE;
        else if (inst_bltu) dec.br_kind = BR_BLTU;
        else if (inst_bgeu) dec.br_kind = BR_BGEU;
        else                dec.br_kind = BR_NONE;

        dec.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
        dec.src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti
                        | inst_sltui | inst_andi | inst_ori | inst_xori | inst_lu12i_w
                        | inst_pcaddu12i | inst_jirl | inst_bl;

        // illegal encodings read nothing
        dec.use_rj  = legal & ~(inst_b | inst_bl | inst_lu12i_w | inst_pcaddu12i);
        dec.use_rkd = (grp_3r & legal) | is_cond_br;
        dec.raddr1  = rj;
        dec.raddr2  = is_cond_br ? rd : rk;

        dec.gr_we = legal & ~is_cond_br & ~inst_b;
        dec.dest  = inst_bl ? 5'd1 : rd;

        // link value for bl and jirl
        if (inst_bl | inst_jirl)
            dec.imm = 32'd4;
        else if (inst_lu12i_w | inst_pcaddu12i)
            dec.imm = {i20, 12'b0};
        else if (inst_andi | inst_ori | inst_xori)
            dec.imm = {20'b0, i12};
        else
            dec.imm = {{20{i12[11]}}, i12};

        if (inst_b | inst_bl)
            dec.br_offs = {{4{i26[25]}}, i26, 2'b0};
        else
            dec.br_offs = {{14{i16[15]}}, i16, 2'b0};

        dec.ine = ~legal;
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  id_pkg::wb_t       wb
);
    import id_pkg::*;

    word_t rf [32];

    // r0 is hardwired, writes to it are dropped
    always_ff @(posedge clk) begin
        if (wb.we && (wb.waddr != '0)) begin
            rf[wb.waddr] <= wb.wdata;
        end
    end

    always_comb begin
        if (raddr1 == '0)
            rdata1 = '0;
        else
            rdata1 = rf[raddr1];
    end

    always_comb begin
        if (raddr2 == '0)
            rdata2 = '0;
        else
            rdata2 = rf[raddr2];
    end

endmodule

// File: verilog/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass (
    input  id_pkg::dec_t     dec,
    input  id_pkg::word_t    rdata1,
    input  id_pkg::word_t    rdata2,
    input  id_pkg::fwd_src_t es_fwd,
    input  id_pkg::fwd_src_t ms_fwd,
    input  id_pkg::wb_t      wb,
    output id_pkg::word_t    rj_value,
    output id_pkg::word_t    rkd_value,
    output logic             stall
);
    import id_pkg::*;

    logic es_hit1;
    logic es_hit2;
    logic ms_hit1;
    logic ms_hit2;
    logic wb_hit1;
    logic wb_hit2;
    logic stall1;
    logic stall2;

    // producer writes a real register that this source actually reads
    function automatic logic src_hit(input logic we, input reg_addr_t waddr,
                                     input reg_addr_t src, input logic used);
        return used && we && (waddr != '0) && (waddr == src);
    endfunction

    assign es_hit1 = src_hit(es_fwd.write, es_fwd.waddr, dec.raddr1, dec.use_rj);
    assign ms_hit1 = src_hit(ms_fwd.write, ms_fwd.waddr, dec.raddr1, dec.use_rj);
    assign wb_hit1 = src_hit(wb.we, wb.waddr, dec.raddr1, dec.use_rj);

    assign es_hit2 = src_hit(es_fwd.write, es_fwd.waddr, dec.raddr2, dec.use_rkd);
    assign ms_hit2 = src_hit(ms_fwd.write, ms_fwd.waddr, dec.raddr2, dec.use_rkd);
    assign wb_hit2 = src_hit(wb.we, wb.waddr, dec.raddr2, dec.use_rkd);

    // youngest producer wins
    assign rj_value  = es_hit1 ? es_fwd.wdata :
                       ms_hit1 ? ms_fwd.wdata :
                       wb_hit1 ? wb.wdata     :
                                 rdata1;
    assign rkd_value = es_hit2 ? es_fwd.wdata :
                       ms_hit2 ? ms_fwd.wdata :
                       wb_hit2 ? wb.wdata     :
                                 rdata2;

    // only the producer that would be forwarded matters
    assign stall1 = es_hit1 ? es_fwd.pending : (ms_hit1 & ms_fwd.pending);
    assign stall2 = es_hit2 ? es_fwd.pending : (ms_hit2 & ms_fwd.pending);
    assign stall  = stall1 | stall2;

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve (
    input  id_pkg::br_kind_e br_kind,
    input  id_pkg::word_t    pc,
    input  id_pkg::word_t    rj_value,
    input  id_pkg::word_t    rkd_value,
    input  id_pkg::word_t    br_offs,
    output logic             cond_taken,
    output id_pkg::word_t    target
);
    import id_pkg::*;

    logic [XLEN:0] diff;
    logic          eq;
    logic          lt_s;
    logic          lt_u;
    word_t         base;

    // one subtractor feeds both compares
    assign diff = {1'b0, rj_value} - {1'b0, rkd_value};
    assign eq   = (rj_value == rkd_value);
    assign lt_u = diff[XLEN];
    // signs differ: the negative one is smaller
    assign lt_s = (rj_value[XLEN-1] & ~rkd_value[XLEN-1])
                | (~(rj_value[XLEN-1] ^ rkd_value[XLEN-1]) & diff[XLEN-1]);

    always_comb begin
        case (br_kind)
            BR_B,
            BR_BL,
            BR_JIRL:  cond_taken = 1'b1;
            BR_BEQ:   cond_taken = eq;
            BR_BNE:   cond_taken = ~eq;
            BR_BLT:   cond_taken = lt_s;
            BR_BGE:   cond_taken = ~lt_s;
            BR_BLTU:  cond_taken = lt_u;
            BR_BGEU:  cond_taken = ~lt_u;
            default:  cond_taken = 1'b0;
        endcase
    end

    assign base   = (br_kind == BR_JIRL) ? rj_value : pc;
    assign target = base + br_offs;

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  id_pkg::fetch_pkt_t   in_pkt,
    output logic                 out_valid,
    input  logic                 out_ready,
    output id_pkg::exe_pkt_t     out_pkt,
    output id_pkg::br_t          br,
    input  id_pkg::fwd_src_t     es_fwd,
    input  id_pkg::fwd_src_t     ms_fwd,
    input  id_pkg::wb_t          wb
);
    import id_pkg::*;

    logic       slot_valid;
    fetch_pkt_t slot_pkt;
    dec_t       dec;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      rj_value;
    word_t      rkd_value;
    logic       stall;
    logic       cond_taken;
    word_t      br_target;
    logic       out_fire;
    logic       br_fire;

    inst_decoder u_decoder (
        .inst (slot_pkt.inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.raddr1),
        .raddr2 (dec.raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wb     (wb)
    );

    operand_bypass u_bypass (
        .dec       (dec),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .wb        (wb),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_resolve u_branch (
        .br_kind    (dec.br_kind),
        .pc         (slot_pkt.pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .br_offs    (dec.br_offs),
        .cond_taken (cond_taken),
        .target     (br_target)
    );

    assign out_valid = slot_valid & ~stall;
    assign out_fire  = out_valid & out_ready;
    assign in_ready  = ~slot_valid | out_fire;
    // redirect only when the branch itself leaves the stage
    assign br_fire   = out_fire & cond_taken;

    assign br.taken  = br_fire;
    assign br.target = br_target;

    // a taken branch squashes whatever fetch offers alongside it
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (br_fire) begin
            slot_valid <= 1'b0;
        end else if (in_ready) begin
            slot_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            slot_pkt <= in_pkt;
        end
    end

    always_comb begin
        out_pkt.alu_op      = dec.alu_op;
        out_pkt.src1_is_pc  = dec.src1_is_pc;
        out_pkt.src2_is_imm = dec.src2_is_imm;
        out_pkt.gr_we       = dec.gr_we;
        out_pkt.dest        = dec.dest;
        out_pkt.imm         = dec.imm;
        out_pkt.rj_value    = rj_value;
        out_pkt.rkd_value   = rkd_value;
        out_pkt.pc          = slot_pkt.pc;
        out_pkt.ine         = dec.ine;
    end

endmodule

// File: verification/id_tb_tasks.svh
`ifndef ID_TB_TASKS_SVH
`define ID_TB_TASKS_SVH

function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic word_t enc_3r(input logic [4:0] func, input reg_addr_t rk,
                                 input reg_addr_t rj, input reg_addr_t rd);
    return {6'h00, 4'h0, 2'h1, func, rk, rj, rd};
endfunction

function automatic word_t enc_shift(input logic [4:0] func, input logic [4:0] ui5,
                                    input reg_addr_t rj, input reg_addr_t rd);
    return {6'h00, 4'h1, 2'h0, func, ui5, rj, rd};
endfunction

function automatic word_t enc_ri12(input logic [3:0] opi, input logic [11:0] i12,
                                   input reg_addr_t rj, input reg_addr_t rd);
    return {6'h00, opi, i12, rj, rd};
endfunction

function automatic word_t enc_ri20(input logic [5:0] op, input logic [19:0] i20,
                                   input reg_addr_t rd);
    return {op, 1'b0, i20, rd};
endfunction

function automatic word_t enc_br16(input logic [5:0] op, input logic [15:0] offs,
                                   input reg_addr_t rj, input reg_addr_t rd);
    return {op, offs, rj, rd};
endfunction

// offs[25:16] lands in the low ten bits
function automatic word_t enc_br26(input logic [5:0] op, input logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
endfunction

function automatic exe_pkt_t make_pkt(input alu_op_e alu, input logic s1pc, input logic s2imm,
                                      input logic we, input reg_addr_t dest, input word_t imm,
                                      input word_t rj, input word_t rkd, input word_t pc,
                                      input logic ine);
    exe_pkt_t p;
    p.alu_op      = alu;
    p.src1_is_pc  = s1pc;
    p.src2_is_imm = s2imm;
    p.gr_we       = we;
    p.dest        = dest;
    p.imm         = imm;
    p.rj_value    = rj;
    p.rkd_value   = rkd;
    p.pc          = pc;
    p.ine         = ine;
    return p;
endfunction

task automatic compare_exe(input exe_pkt_t got, input exe_pkt_t exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s packet got %h exp %h", $time, what, got, exp);
        abort_run("execute packet mismatch");
    end
endtask

task automatic compare_br(input br_t got, input br_t exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s branch got %h exp %h", $time, what, got, exp);
        abort_run("branch result mismatch");
    end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s got %b exp %b", $time, what, got, exp);
        abort_run("handshake signal mismatch");
    end
endtask

task automatic write_reg(input reg_addr_t addr, input word_t data);
    @(negedge clk);
    wb.we    = 1'b1;
    wb.waddr = addr;
    wb.wdata = data;
    @(negedge clk);
    wb = '0;
    if (addr != 5'd0) begin
        rf_model[addr] = data;
    end
endtask

// returns on the falling edge after the slot took the instruction
task automatic issue(input word_t inst, input word_t pc);
    int waited;
    @(negedge clk);
    in_valid    = 1'b1;
    in_pkt.inst = inst;
    in_pkt.pc   = pc;
    waited      = 0;
    #1;
    while (!in_ready) begin
        if (waited == WAIT_LIMIT) begin
            abort_run("in_ready never rose for a new instruction");
        end
        @(negedge clk);
        #1;
        waited++;
    end
    @(negedge clk);
    in_valid = 1'b0;
endtask

task automatic wait_out();
    int waited;
    waited = 0;
    #1;
    while (!out_valid) begin
        if (waited == WAIT_LIMIT) begin
            abort_run("out_valid never rose for a decoded instruction");
        end
        @(negedge clk);
        #1;
        waited++;
    end
endtask

task automatic check_out(input exe_pkt_t exp, input string what);
    wait_out();
    compare_exe(out_pkt, exp, what);
endtask

task automatic test_regfile();
    word_t inst;
    for (int i = 1; i < 32; i++) begin
        write_reg(i[4:0], lcg_next());
    end
    write_reg(5'd0, lcg_next());
    inst = enc_3r(F_ADD, 5'd7, 5'd6, 5'd5);
    issue(inst, 32'h1c00_0000);
    check_out(make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b1, 5'd5, sext12(inst[21:10]),
                       rf_model[6], rf_model[7], 32'h1c00_0000, 1'b0), "regfile read");
    inst = enc_3r(F_ADD, 5'd8, 5'd0, 5'd1);
    issue(inst, 32'h1c00_0004);
    check_out(make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b1, 5'd1, sext12(inst[21:10]),
                       32'd0, rf_model[8], 32'h1c00_0004, 1'b0), "r0 read");
endtask

task automatic decode_one(input word_t inst, input word_t pc, input alu_op_e alu,
                          input logic s1pc, input logic s2imm, input logic we,
                          input word_t imm, input logic ine, input string what);
    issue(inst, pc);
    check_out(make_pkt(alu, s1pc, s2imm, we, inst[4:0], imm, rf_model[inst[9:5]],
                       rf_model[inst[14:10]], pc, ine), what);
endtask

task automatic test_decode();
    word_t inst;
    inst = enc_3r(F_ADD, 5'd2, 5'd1, 5'd3);
    decode_one(inst, 32'h1c00_0100, ALU_ADD, 1'b0, 1'b0, 1'b1, sext12(inst[21:10]), 1'b0, "add.w");
    inst = enc_3r(F_SUB, 5'd6, 5'd5, 5'd4);
    decode_one(inst, 32'h1c00_0104, ALU_SUB, 1'b0, 1'b0, 1'b1, sext12(inst[21:10]), 1'b0, "sub.w");
    inst = enc_ri12(OPI_SLTI, 12'hffd, 5'd8, 5'd7);
    decode_one(inst, 32'h1c00_0108, ALU_SLT, 1'b0, 1'b1, 1'b1, 32'hffff_fffd, 1'b0, "slti");
    inst = enc_ri12(OPI_ANDI, 12'h8f0, 5'd10, 5'd9);
    decode_one(inst, 32'h1c00_010c, ALU_AND, 1'b0, 1'b1, 1'b1, 32'h0000_08f0, 1'b0, "andi");
    inst = enc_ri20(OP_LU12I, 20'h81234, 5'd11);
    decode_one(inst, 32'h1c00_0110, ALU_LUI, 1'b0, 1'b1, 1'b1, 32'h8123_4000, 1'b0, "lu12i.w");
    inst = enc_ri20(OP_PCADDU, 20'h00fff, 5'd12);
    decode_one(inst, 32'h1c00_0114, ALU_ADD, 1'b1, 1'b1, 1'b1, 32'h00ff_f000, 1'b0, "pcaddu12i");
    inst = enc_shift(F_SRAI, 5'd5, 5'd14, 5'd13);
    decode_one(inst, 32'h1c00_0118, ALU_SRA, 1'b0, 1'b1, 1'b1, sext12(inst[21:10]), 1'b0, "srai.w");
    // unused primary opcode
    inst = 32'hffff_ffff;
    decode_one(inst, 32'h1c00_011c, ALU_ADD, 1'b0, 1'b0, 1'b0, 32'hffff_ffff, 1'b1, "illegal");
endtask

task automatic set_fwd(input reg_addr_t addr, input word_t es_d, input word_t ms_d,
                       input word_t wb_d);
    @(negedge clk);
    es_fwd.write   = 1'b1;
    es_fwd.pending = 1'b0;
    es_fwd.waddr   = addr;
    es_fwd.wdata   = es_d;
    ms_fwd.write   = 1'b1;
    ms_fwd.pending = 1'b0;
    ms_fwd.waddr   = addr;
    ms_fwd.wdata   = ms_d;
    wb.we          = 1'b1;
    wb.waddr       = addr;
    wb.wdata       = wb_d;
    if (addr != 5'd0) begin
        rf_model[addr] = wb_d;
    end
endtask

task automatic test_forward();
    word_t inst;
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    a    = lcg_next();
    b    = lcg_next();
    c    = lcg_next();
    // differs from what the register file already holds for r9
    d    = ~c;
    inst = enc_3r(F_ADD, 5'd9, 5'd9, 5'd10);
    set_fwd(5'd9, a, b, c);
    issue(inst, 32'h1c00_0200);
    check_out(make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b1, 5'd10, sext12(inst[21:10]), a, a,
                       32'h1c00_0200, 1'b0), "es forward");
    @(negedge clk);
    es_fwd = '0;
    issue(inst, 32'h1c00_0204);
    check_out(make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b1, 5'd10, sext12(inst[21:10]), b, b,
                       32'h1c00_0204, 1'b0), "ms forward");
    @(negedge clk);
    ms_fwd = '0;
    wb     = '0;
    issue(inst, 32'h1c00_0208);
    // writeback lands in the same cycle the slot reads r9
    wb.we       = 1'b1;
    wb.waddr    = 5'd9;
    wb.wdata    = d;
    rf_model[9] = d;
    check_out(make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b1, 5'd10, sext12(inst[21:10]), d, d,
                       32'h1c00_0208, 1'b0), "wb forward");
    // producers aimed at r0
    inst = enc_3r(F_ADD, 5'd0, 5'd0, 5'd10);
    set_fwd(5'd0, a, b, c);
    issue(inst, 32'h1c00_020c);
    check_out(make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b1, 5'd10, sext12(inst[21:10]), 32'd0, 32'd0,
                       32'h1c00_020c, 1'b0), "r0 forward");
    @(negedge clk);
    es_fwd = '0;
    ms_fwd = '0;
    wb     = '0;
endtask

task automatic test_stall();
    word_t inst;
    word_t a;
    a    = lcg_next();
    inst = enc_3r(F_ADD, 5'd0, 5'd11, 5'd12);
    @(negedge clk);
    es_fwd.write   = 1'b1;
    es_fwd.pending = 1'b1;
    es_fwd.waddr   = 5'd11;
    es_fwd.wdata   = a;
    issue(inst, 32'h1c00_0300);
    repeat (3) begin
        #1;
        compare_bit(out_valid, 1'b0, "out_valid during stall");
        compare_bit(in_ready, 1'b0, "in_ready during stall");
        @(negedge clk);
    end
    es_fwd.pending = 1'b0;
    check_out(make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b1, 5'd12, sext12(inst[21:10]), a, 32'd0,
                       32'h1c00_0300, 1'b0), "stall release");
    @(negedge clk);
    es_fwd = '0;
endtask

task automatic run_branch(input word_t inst, input word_t pc, input logic taken,
                          input word_t target, input exe_pkt_t exp);
    br_t exp_br;
    issue(inst, pc);
    if (taken) begin
        // offered alongside the redirect, must be squashed
        in_valid    = 1'b1;
        in_pkt.inst = enc_ri12(OPI_ADDI, 12'h7ff, 5'd0, 5'd20);
        in_pkt.pc   = 32'hdead_0000;
    end
    wait_out();
    compare_exe(out_pkt, exp, "branch");
    if (taken) begin
        exp_br.taken  = 1'b1;
        exp_br.target = target;
        compare_br(br, exp_br, "taken branch");
    end else begin
        compare_bit(br.taken, 1'b0, "br.taken on not-taken branch");
    end
    @(negedge clk);
    in_valid = 1'b0;
    #1;
    if (taken) begin
        compare_bit(out_valid, 1'b0, "out_valid after taken branch");
    end
endtask

task automatic test_branch();
    word_t       inst;
    word_t       pc;
    word_t       a;
    word_t       b;
    logic        taken;
    word_t       av [4];
    word_t       bv [4];
    logic [5:0]  ops [6];
    av  = '{32'd5, 32'd5, 32'hffff_ffff, 32'd1};
    bv  = '{32'd5, 32'd6, 32'd1, 32'hffff_ffff};
    ops = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    pc  = 32'h1c00_1000;
    for (int p = 0; p < 4; p++) begin
        a = av[p];
        b = bv[p];
        write_reg(5'd13, a);
        write_reg(5'd14, b);
        for (int k = 0; k < 6; k++) begin
            case (ops[k])
                OP_BEQ:  taken = (a == b);
                OP_BNE:  taken = (a != b);
                OP_BLT:  taken = ($signed(a) < $signed(b));
                OP_BGE:  taken = ($signed(a) >= $signed(b));
                OP_BLTU: taken = (a < b);
                default: taken = (a >= b);
            endcase
            inst = enc_br16(ops[k], 16'hfff0, 5'd13, 5'd14);
            run_branch(inst, pc, taken, pc - 32'd64,
                       make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b0, 5'd14, sext12(inst[21:10]),
                                a, b, pc, 1'b0));
            pc = pc + 32'd4;
        end
    end
    inst = enc_br26(OP_B, 26'h3ff_fff8);
    run_branch(inst, pc, 1'b1, pc - 32'd32,
               make_pkt(ALU_ADD, 1'b0, 1'b0, 1'b0, inst[4:0], sext12(inst[21:10]),
                        rf_model[inst[9:5]], rf_model[inst[14:10]], pc, 1'b0));
    pc   = pc + 32'd4;
    inst = enc_br26(OP_BL, 26'h000_0100);
    run_branch(inst, pc, 1'b1, pc + 32'h400,
               make_pkt(ALU_ADD, 1'b1, 1'b1, 1'b1, 5'd1, 32'd4,
                        rf_model[inst[9:5]], rf_model[inst[14:10]], pc, 1'b0));
    pc   = pc + 32'd4;
    inst = enc_br16(OP_JIRL, 16'h0010, 5'd13, 5'd15);
    run_branch(inst, pc, 1'b1, rf_model[13] + 32'd64,
               make_pkt(ALU_ADD, 1'b1, 1'b1, 1'b1, 5'd15, 32'd4,
                        rf_model[13], rf_model[inst[14:10]], pc, 1'b0));
endtask

task automatic test_backpressure();
    word_t    ia;
    word_t    ib;
    exe_pkt_t ea;
    exe_pkt_t eb;
    ia = enc_3r(F_OR, 5'd2, 5'd1, 5'd3);
    ib = enc_3r(F_XOR, 5'd4, 5'd5, 5'd6);
    ea = make_pkt(ALU_OR, 1'b0, 1'b0, 1'b1, 5'd3, sext12(ia[21:10]), rf_model[1],
                  rf_model[2], 32'h1c00_0400, 1'b0);
    eb = make_pkt(ALU_XOR, 1'b0, 1'b0, 1'b1, 5'd6, sext12(ib[21:10]), rf_model[5],
                  rf_model[4], 32'h1c00_0404, 1'b0);
    @(negedge clk);
    out_ready = 1'b0;
    issue(ia, 32'h1c00_0400);
    in_valid    = 1'b1;
    in_pkt.inst = ib;
    in_pkt.pc   = 32'h1c00_0404;
    repeat (3) begin
        #1;
        compare_bit(out_valid, 1'b1, "out_valid under back-pressure");
        compare_bit(in_ready, 1'b0, "in_ready under back-pressure");
        compare_exe(out_pkt, ea, "held");
        @(negedge clk);
    end
    out_ready = 1'b1;
    #1;
    compare_exe(out_pkt, ea, "first after release");
    compare_bit(in_ready, 1'b1, "in_ready after release");
    @(negedge clk);
    in_valid = 1'b0;
    check_out(eb, "second after release");
    @(negedge clk);
endtask

`endif

// File: verification/tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage;
    import id_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int CLK_PERIOD = 20;
    localparam int WAIT_LIMIT = 50;

    logic       clk;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    fetch_pkt_t in_pkt;
    logic       out_valid;
    logic       out_ready;
    exe_pkt_t   out_pkt;
    br_t        br;
    fwd_src_t   es_fwd;
    fwd_src_t   ms_fwd;
    wb_t        wb;

    // expected register contents
    word_t       rf_model [32];
    logic [31:0] lcg_state;

    id_stage dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt),
        .br        (br),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("TESTS FAILED");
        $fatal(1, "%s", msg);
    endtask

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    `include "id_tb_tasks.svh"

    // each test gets 200 cycles
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        abort_run("watchdog expired before all tests finished");
    end

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_pkt    = '0;
        out_ready = 1'b1;
        es_fwd    = '0;
        ms_fwd    = '0;
        wb        = '0;
        lcg_state = 32'h47df;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_regfile();
        test_decode();
        test_forward();
        test_stall();
        test_branch();
        test_backpressure();

        @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: list.f
+incdir+verification
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_bypass.sv
verilog/branch_resolve.sv
verilog/id_stage.sv
verification/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_id_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_id_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
